// ==== sim.f ====
+incdir+common
common/pq_pkg.sv
rtl/pq_store.sv
rtl/pq_mem_arbiter.sv
pq_insert/pq_insert_ctrl.sv
pq_insert/pq_compare_swap.sv
rtl/pq_remove.sv
rtl/pq_top.sv
test/pq_sva.sv
test/pq_tb.sv

// ==== Makefile ====
TOP := pq_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== test/pq_tb.sv ====
`include "pq_consts.svh"

module pq_tb
  import pq_pkg::*;
();

  localparam logic [31:0] SEED       = 32'h58aee136;
  // About 330 commands, each up to 3*16+4 cycles plus a wait on the other engine
  localparam int          MAX_CYCLES = 20000;

  logic                  clk;
  logic                  rst;
  logic                  enq;
  logic [`PQ_DATA_W-1:0] enq_key;
  logic                  deq;
  pq_enq_resp_t          enq_resp;
  pq_deq_resp_t          deq_resp;
  logic                  enq_busy;
  logic                  deq_busy;

  // Reference list, smallest first
  logic [`PQ_DATA_W-1:0] model_q [$];
  // Keys of enqueues still waiting for a response
  logic [`PQ_DATA_W-1:0] enq_keys [$];
  int                    sent_deq;
  int                    got_deq;
  int                    cycles;

  pq_top pq_top_i (
    .clk      (clk),
    .rst      (rst),
    .enq      (enq),
    .enq_key  (enq_key),
    .deq      (deq),
    .enq_resp (enq_resp),
    .deq_resp (deq_resp),
    .enq_busy (enq_busy),
    .deq_busy (deq_busy)
  );

  bind pq_top pq_sva pq_sva_i (
    .clk      (clk),
    .rst      (rst),
    .enq      (enq),
    .deq      (deq),
    .enq_busy (enq_busy),
    .deq_busy (deq_busy),
    .ins_gnt  (ins_gnt),
    .rem_gnt  (rem_gnt),
    .count    (count),
    .enq_resp (enq_resp),
    .deq_resp (deq_resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Sorted insert, refused at depth
  function automatic pq_enq_resp_t ref_enq(input logic [`PQ_DATA_W-1:0] key);
    pq_enq_resp_t          exp;
    int                    i;
    logic [`PQ_DATA_W-1:0] tmp;
    exp.valid = 1'b1;
    if (model_q.size() == `PQ_DEPTH)
    begin
      exp.rejected = 1'b1;
    end
    else
    begin
      exp.rejected = 1'b0;
      model_q.push_back(key);
      i = model_q.size() - 1;
      // Bubble down to its place
      while ((i > 0) && (model_q[i-1] > model_q[i]))
      begin
        tmp          = model_q[i-1];
        model_q[i-1] = model_q[i];
        model_q[i]   = tmp;
        i            = i - 1;
      end
    end
    return exp;
  endfunction

  // Minimum key, or empty
  function automatic pq_deq_resp_t ref_deq();
    pq_deq_resp_t exp;
    exp.valid = 1'b1;
    exp.key   = '0;
    if (model_q.size() == 0)
    begin
      exp.empty = 1'b1;
    end
    else
    begin
      exp.empty = 1'b0;
      exp.key   = model_q.pop_front();
    end
    return exp;
  endfunction

  // Narrow range forces duplicates
  function automatic logic [`PQ_DATA_W-1:0] rand_key(input logic narrow);
    if (narrow)
    begin
      return `PQ_DATA_W'($urandom_range(0, 7));
    end
    else
    begin
      return `PQ_DATA_W'($urandom);
    end
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_enq(input pq_enq_resp_t got, input pq_enq_resp_t exp);
    if (got !== exp)
    begin
      $display("error: enq_resp got %h expected %h", got, exp);
      $display("Errors found");
      $fatal(1, "enqueue response mismatch");
    end
  endtask

  // Key ignored on empty
  task automatic check_deq(input pq_deq_resp_t got, input pq_deq_resp_t exp);
    if ((got.valid !== exp.valid) || (got.empty !== exp.empty) ||
        (!exp.empty && (got.key !== exp.key)))
    begin
      $display("error: deq_resp got %h expected %h", got, exp);
      $display("Errors found");
      $fatal(1, "dequeue response mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic report_stray(input string what);
    $display("A %s response arrived with no command pending", what);
    $display("Errors found");
    $fatal(1, "stray response");
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic send_enq(input logic [`PQ_DATA_W-1:0] key);
    @(posedge clk);
    while (enq_busy)
    begin
      @(posedge clk);
    end
    enq     <= 1'b1;
    enq_key <= key;
    enq_keys.push_back(key);
    @(posedge clk);
    enq <= 1'b0;
  endtask

  task automatic send_deq();
    @(posedge clk);
    while (deq_busy)
    begin
      @(posedge clk);
    end
    deq      <= 1'b1;
    sent_deq = sent_deq + 1;
    @(posedge clk);
    deq <= 1'b0;
  endtask

  // Both strobes in one cycle, arbiter picks the order
  task automatic send_both(input logic [`PQ_DATA_W-1:0] key);
    @(posedge clk);
    while (enq_busy || deq_busy)
    begin
      @(posedge clk);
    end
    enq      <= 1'b1;
    enq_key  <= key;
    deq      <= 1'b1;
    enq_keys.push_back(key);
    sent_deq = sent_deq + 1;
    @(posedge clk);
    enq <= 1'b0;
    deq <= 1'b0;
  endtask

  // Busy covers the response cycle
  task automatic wait_idle();
    @(posedge clk);
    while ((enq_keys.size() != 0) || (got_deq != sent_deq) || enq_busy || deq_busy)
    begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////

  // Response order equals grant order, so the model follows it
  always @(posedge clk)
  begin
    if (!rst && enq_resp.valid)
    begin
      if (enq_keys.size() == 0)
      begin
        report_stray("enqueue");
      end
      else
      begin
        check_enq(enq_resp, ref_enq(enq_keys.pop_front()));
      end
    end
    if (!rst && deq_resp.valid)
    begin
      if (got_deq == sent_deq)
      begin
        report_stray("dequeue");
      end
      else
      begin
        got_deq = got_deq + 1;
        check_deq(deq_resp, ref_deq());
      end
    end
  end

  // Run limit
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout after %0d cycles, a response never arrived", MAX_CYCLES);
    $display("Errors found");
    $fatal(1, "simulation timed out");
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    int i;
    int pick;
    void'($urandom(SEED));
    sent_deq = 0;
    got_deq  = 0;
    rst     <= 1'b1;
    enq     <= 1'b0;
    enq_key <= '0;
    deq     <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Quiet after reset, dequeue finds it empty
    @(posedge clk);
    check_flag("enq_busy", enq_busy, 1'b0);
    check_flag("deq_busy", deq_busy, 1'b0);
    check_flag("enq_resp.valid", enq_resp.valid, 1'b0);
    check_flag("deq_resp.valid", deq_resp.valid, 1'b0);
    send_deq();
    wait_idle();

    // Random keys out in ascending order
    // Nine narrow keys over eight values always repeat one
    for (i = 0; i < 12; i++)
    begin
      send_enq(rand_key(i % 4 != 0));
    end
    wait_idle();
    for (i = 0; i < 12; i++)
    begin
      send_deq();
    end
    wait_idle();

    // Fill, one refused, drain plus one empty
    for (i = 0; i < `PQ_DEPTH; i++)
    begin
      send_enq(rand_key(i[0]));
    end
    send_enq(rand_key(1'b0));
    wait_idle();
    for (i = 0; i <= `PQ_DEPTH; i++)
    begin
      send_deq();
    end
    wait_idle();

    // Same-cycle strobes
    for (i = 0; i < 3; i++)
    begin
      send_enq(rand_key(1'b0));
    end
    for (i = 0; i < 6; i++)
    begin
      send_both(rand_key(i[0]));
    end
    wait_idle();
    for (i = 0; i < 4; i++)
    begin
      send_deq();
    end
    send_both(rand_key(1'b0));
    send_deq();
    wait_idle();

    // Long random mix, engines overlap
    for (i = 0; i < 200; i++)
    begin
      pick = int'($urandom_range(0, 9));
      if (pick < 5)
      begin
        send_enq(rand_key(pick[0]));
      end
      else if (pick < 8)
      begin
        send_deq();
      end
      else
      begin
        send_both(rand_key(1'b1));
      end
    end
    wait_idle();

    $display("No errors");
    $finish;
  end

endmodule

// ==== test/pq_sva.sv ====
`include "pq_consts.svh"

module pq_sva
  import pq_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 enq,
  input logic                 deq,
  input logic                 enq_busy,
  input logic                 deq_busy,
  input logic                 ins_gnt,
  input logic                 rem_gnt,
  input logic [`PQ_CNT_W-1:0] count,
  input pq_enq_resp_t         enq_resp,
  input pq_deq_resp_t         deq_resp
);

  ////////////////////////////////////////
  // Command protocol
  ////////////////////////////////////////

  // No strobe into a busy engine
  enq_idle_a: assert property (@(posedge clk) disable iff (rst) enq |-> !enq_busy)
    else $error("enq strobe while insert engine busy");

  deq_idle_a: assert property (@(posedge clk) disable iff (rst) deq |-> !deq_busy)
    else $error("deq strobe while remove engine busy");

  ////////////////////////////////////////
  // Store sharing and occupancy
  ////////////////////////////////////////

  // One owner at a time
  gnt_onehot_a: assert property (@(posedge clk) disable iff (rst) !(ins_gnt && rem_gnt))
    else $error("both engines granted");

  count_max_a: assert property (@(posedge clk) disable iff (rst) count <= `PQ_DEPTH)
    else $error("occupancy above depth");

  // Responses are single-cycle strobes
  enq_pulse_a: assert property (@(posedge clk) disable iff (rst)
    enq_resp.valid |=> !enq_resp.valid)
    else $error("enq_resp valid longer than one cycle");

  deq_pulse_a: assert property (@(posedge clk) disable iff (rst)
    deq_resp.valid |=> !deq_resp.valid)
    else $error("deq_resp valid longer than one cycle");

endmodule

// ==== rtl/pq_top.sv ====
`include "pq_consts.svh"

module pq_top
  import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enq,
  input  logic [`PQ_DATA_W-1:0] enq_key,
  input  logic                  deq,
  output pq_enq_resp_t          enq_resp,
  output pq_deq_resp_t          deq_resp,
  output logic                  enq_busy,
  output logic                  deq_busy
);

  ////////////////////////////////////////
  // Wires
  ////////////////////////////////////////

  // Insert engine
  logic                  ins_req_on;
  logic                  ins_gnt;
  pq_mem_op_t            ins_op;
  logic                  load_carry;
  logic                  swap_carry;
  logic                  idx_inc;
  logic                  greater;
  logic                  at_end;
  logic [`PQ_ADDR_W-1:0] ins_addr;
  logic [`PQ_DATA_W-1:0] ins_wkey;
  pq_mem_req_t           ins_req;

  // Remove engine
  logic                  rem_req_on;
  logic                  rem_gnt;
  pq_mem_req_t           rem_req;

  // Store port
  pq_mem_req_t           mem_req;
  logic [`PQ_DATA_W-1:0] rdata;
  logic [`PQ_CNT_W-1:0]  count;

  // Controller opcode with datapath address and key
  assign ins_req.op   = ins_op;
  assign ins_req.addr = ins_addr;
  assign ins_req.key  = ins_wkey;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  pq_insert_ctrl pq_insert_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .enq        (enq),
    .gnt        (ins_gnt),
    .count      (count),
    .greater    (greater),
    .at_end     (at_end),
    .req_on     (ins_req_on),
    .op         (ins_op),
    .load_carry (load_carry),
    .swap_carry (swap_carry),
    .idx_inc    (idx_inc),
    .busy       (enq_busy),
    .enq_resp   (enq_resp)
  );

  pq_compare_swap pq_compare_swap_i (
    .clk        (clk),
    .rst        (rst),
    .enq_key    (enq_key),
    .rdata      (rdata),
    .count      (count),
    .load_carry (load_carry),
    .swap_carry (swap_carry),
    .idx_inc    (idx_inc),
    .greater    (greater),
    .at_end     (at_end),
    .addr       (ins_addr),
    .wkey       (ins_wkey)
  );

  pq_remove pq_remove_i (
    .clk      (clk),
    .rst      (rst),
    .deq      (deq),
    .gnt      (rem_gnt),
    .count    (count),
    .rdata    (rdata),
    .req_on   (rem_req_on),
    .req      (rem_req),
    .busy     (deq_busy),
    .deq_resp (deq_resp)
  );

  pq_mem_arbiter pq_mem_arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .ins_req_on (ins_req_on),
    .ins_req    (ins_req),
    .rem_req_on (rem_req_on),
    .rem_req    (rem_req),
    .ins_gnt    (ins_gnt),
    .rem_gnt    (rem_gnt),
    .mem_req    (mem_req)
  );

  pq_store pq_store_i (
    .clk   (clk),
    .rst   (rst),
    .req   (mem_req),
    .rdata (rdata),
    .count (count)
  );

endmodule

// ==== rtl/pq_remove.sv ====
`include "pq_consts.svh"

module pq_remove
  import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  deq,
  input  logic                  gnt,
  input  logic [`PQ_CNT_W-1:0]  count,
  input  logic [`PQ_DATA_W-1:0] rdata,
  output logic                  req_on,
  output pq_mem_req_t           req,
  output logic                  busy,
  output pq_deq_resp_t          deq_resp
);

  pq_rem_state_t         state;
  pq_rem_state_t         next_state;
  // Sampled at grant, held through the response
  logic                  empty_q;
  logic                  resp_valid_q;
  logic [`PQ_DATA_W-1:0] resp_key_q;
  // Slot of the smallest key
  logic [`PQ_CNT_W-1:0]  last_slot;

  assign last_slot = count - 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= REM_IDLE;
      empty_q      <= 1'b0;
      resp_valid_q <= 1'b0;
    end
    else
    begin
      state        <= next_state;
      resp_valid_q <= (state == REM_RESPOND);
      if ((state == REM_WAIT_GNT) && gnt)
      begin
        empty_q <= (count == '0);
      end
    end
  end

  // Read data arrives in the respond state
  always_ff @(posedge clk)
  begin
    if (state == REM_RESPOND)
    begin
      resp_key_q <= empty_q ? '0 : rdata;
    end
  end

  ////////////////////////////////////////
  // Pop sequence
  ////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    req.op     = MEM_IDLE;
    req.addr   = last_slot[`PQ_ADDR_W-1:0];
    req.key    = '0;
    case (state)
      REM_IDLE:
      begin
        if (deq)
        begin
          next_state = REM_WAIT_GNT;
        end
      end
      REM_WAIT_GNT:
      begin
        if (gnt)
        begin
          next_state = REM_READ;
        end
      end
      REM_READ:
      begin
        // Nothing to fetch when empty
        if (!empty_q)
        begin
          req.op = MEM_READ;
        end
        next_state = REM_RESPOND;
      end
      REM_RESPOND:
      begin
        if (!empty_q)
        begin
          req.op = MEM_CNT_DEC;
        end
        next_state = REM_IDLE;
      end
      default:
      begin
        next_state = REM_IDLE;
      end
    endcase
  end

  assign req_on = (state != REM_IDLE);
  // Busy through the registered response cycle
  assign busy = (state != REM_IDLE) || resp_valid_q;

  assign deq_resp.valid = resp_valid_q;
  assign deq_resp.empty = empty_q;
  assign deq_resp.key   = resp_key_q;

endmodule

// ==== pq_insert/pq_compare_swap.sv ====
`include "pq_consts.svh"

module pq_compare_swap
  import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`PQ_DATA_W-1:0] enq_key,
  input  logic [`PQ_DATA_W-1:0] rdata,
  input  logic [`PQ_CNT_W-1:0]  count,
  input  logic                  load_carry,
  input  logic                  swap_carry,
  input  logic                  idx_inc,
  output logic                  greater,
  output logic                  at_end,
  output logic [`PQ_ADDR_W-1:0] addr,
  output logic [`PQ_DATA_W-1:0] wkey
);

  // Key in flight during the walk
  logic [`PQ_DATA_W-1:0] carry;
  // Slot under inspection
  logic [`PQ_ADDR_W-1:0] idx;

  ////////////////////////////////////////
  // Carry and walk index
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (load_carry)
    begin
      carry <= enq_key;
    end
    else if (swap_carry)
    begin
      carry <= rdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx <= '0;
    end
    else if (load_carry)
    begin
      idx <= '0;
    end
    else if (idx_inc)
    begin
      idx <= idx + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  // Strict compare keeps equal keys in arrival order
  assign greater = (carry > rdata);

  // Past the last stored key
  assign at_end = (`PQ_CNT_W'(idx) == count);

  // Write path always carries the old carry
  assign addr = idx;
  assign wkey = carry;

endmodule

// ==== pq_insert/pq_insert_ctrl.sv ====
`include "pq_consts.svh"

module pq_insert_ctrl
  import pq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enq,
  input  logic                 gnt,
  input  logic [`PQ_CNT_W-1:0] count,
  input  logic                 greater,
  input  logic                 at_end,
  output logic                 req_on,
  output pq_mem_op_t           op,
  output logic                 load_carry,
  output logic                 swap_carry,
  output logic                 idx_inc,
  output logic                 busy,
  output pq_enq_resp_t         enq_resp
);

  pq_ins_state_t state;
  pq_ins_state_t next_state;
  logic          full;

  // Count is stable while we hold the grant
  assign full = (count == `PQ_CNT_W'(`PQ_DEPTH));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= INS_IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  ////////////////////////////////////////
  // Insert walk
  ////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    op         = MEM_IDLE;
    load_carry = 1'b0;
    swap_carry = 1'b0;
    idx_inc    = 1'b0;
    enq_resp   = '0;
    case (state)
      INS_IDLE:
      begin
        // Key only valid with the strobe
        // Capture it and rewind the index
        if (enq)
        begin
          load_carry = 1'b1;
          next_state = INS_FILL;
        end
      end
      INS_FILL:
      begin
        // Wait for the store
        if (gnt)
        begin
          next_state = INS_COMPARE;
        end
      end
      INS_COMPARE:
      begin
        // Refuse when full, append when past the last key
        if (full || at_end)
        begin
          next_state = INS_FINISH;
        end
        else
        begin
          op         = MEM_READ;
          next_state = INS_SWAP;
        end
      end
      INS_SWAP:
      begin
        // Larger carry takes the slot
        // Displaced key moves on in the carry
        if (greater)
        begin
          op         = MEM_WRITE;
          swap_carry = 1'b1;
        end
        next_state = INS_CNT_INC;
      end
      INS_CNT_INC:
      begin
        // Step to next slot
        idx_inc    = 1'b1;
        next_state = INS_COMPARE;
      end
      INS_FINISH:
      begin
        if (!full)
        begin
          op = MEM_CNT_INC;
        end
        enq_resp.valid    = 1'b1;
        enq_resp.rejected = full;
        next_state        = INS_IDLE;
      end
      default:
      begin
        next_state = INS_IDLE;
      end
    endcase
  end

  // Request held for the whole operation
  assign req_on = (state != INS_IDLE);
  assign busy   = (state != INS_IDLE); // Covers the response cycle

endmodule

// ==== rtl/pq_mem_arbiter.sv ====
module pq_mem_arbiter
  import pq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        ins_req_on,
  input  pq_mem_req_t ins_req,
  input  logic        rem_req_on,
  input  pq_mem_req_t rem_req,
  output logic        ins_gnt,
  output logic        rem_gnt,
  output pq_mem_req_t mem_req
);

  // Owner still requesting
  logic ins_hold;
  logic rem_hold;
  logic lock;
  // Grant for next cycle
  logic pick_ins;
  logic pick_rem;
  // Remove engine won the last new grant
  logic last_rem;

  assign ins_hold = ins_gnt && ins_req_on;
  assign rem_hold = rem_gnt && rem_req_on;
  assign lock     = ins_hold || rem_hold;

  always_comb
  begin
    pick_ins = 1'b0;
    pick_rem = 1'b0;
    if (lock)
    begin
      // Grant stays until the owner drops its flag
      pick_ins = ins_hold;
      pick_rem = rem_hold;
    end
    else if (ins_req_on && rem_req_on)
    begin
      // Tie goes to whoever lost last time
      pick_ins = last_rem;
      pick_rem = !last_rem;
    end
    else
    begin
      pick_ins = ins_req_on;
      pick_rem = rem_req_on;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ins_gnt  <= 1'b0;
      rem_gnt  <= 1'b0;
      last_rem <= 1'b0;
    end
    else
    begin
      ins_gnt <= pick_ins;
      rem_gnt <= pick_rem;
      if (pick_ins || pick_rem)
      begin
        last_rem <= pick_rem;
      end
    end
  end

  // Forward the owner's request, idle otherwise
  always_comb
  begin
    mem_req    = '0;
    mem_req.op = MEM_IDLE;
    if (ins_hold)
    begin
      mem_req = ins_req;
    end
    else if (rem_hold)
    begin
      mem_req = rem_req;
    end
  end

endmodule

// ==== rtl/pq_store.sv ====
`include "pq_consts.svh"

module pq_store
  import pq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  pq_mem_req_t           req,
  output logic [`PQ_DATA_W-1:0] rdata,
  output logic [`PQ_CNT_W-1:0]  count
);

  // Keys kept in descending order
  // Smallest key at slot count-1
  logic [`PQ_DATA_W-1:0] mem [`PQ_DEPTH];

  ////////////////////////////////////////
  // Key array
  ////////////////////////////////////////

  // Registered read, data one cycle later
  always_ff @(posedge clk)
  begin
    if (req.op == MEM_READ)
    begin
      rdata <= mem[req.addr];
    end
  end

  // Plain write or append
  always_ff @(posedge clk)
  begin
    if ((req.op == MEM_WRITE) || (req.op == MEM_CNT_INC))
    begin
      mem[req.addr] <= req.key;
    end
  end

  ////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////

  // No limit checks here
  // Engines only step the count when legal
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (req.op == MEM_CNT_INC)
    begin
      count <= count + 1'b1;
    end
    else if (req.op == MEM_CNT_DEC)
    begin
      count <= count - 1'b1;
    end
  end

endmodule

// ==== common/pq_pkg.sv ====
`include "pq_consts.svh"

package pq_pkg;

  ////////////////////////////////////////
  // Shared store port
  ////////////////////////////////////////

  // Operations the store performs
  // Count increment also stores the key at the address (append)
  typedef enum logic [2:0] {
    MEM_IDLE    = 3'd0,
    MEM_READ    = 3'd1,
    MEM_WRITE   = 3'd2,
    MEM_CNT_INC = 3'd3,
    MEM_CNT_DEC = 3'd4
  } pq_mem_op_t;

  // One request per cycle toward the store
  typedef struct packed {
    pq_mem_op_t            op;
    logic [`PQ_ADDR_W-1:0] addr;
    logic [`PQ_DATA_W-1:0] key;
  } pq_mem_req_t;

  ////////////////////////////////////////
  // Responses
  ////////////////////////////////////////

  // Enqueue done, refused when full
  typedef struct packed {
    logic valid;
    logic rejected;
  } pq_enq_resp_t;

  // Dequeue done, smallest key or empty
  typedef struct packed {
    logic                  valid;
    logic                  empty;
    logic [`PQ_DATA_W-1:0] key;
  } pq_deq_resp_t;

  ////////////////////////////////////////
  // Engine states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    INS_IDLE    = 3'd0,
    INS_FILL    = 3'd1,
    INS_COMPARE = 3'd2,
    INS_SWAP    = 3'd3,
    INS_CNT_INC = 3'd4,
    INS_FINISH  = 3'd5
  } pq_ins_state_t;

  typedef enum logic [1:0] {
    REM_IDLE     = 2'd0,
    REM_WAIT_GNT = 2'd1,
    REM_READ     = 2'd2,
    REM_RESPOND  = 2'd3
  } pq_rem_state_t;

endpackage

// ==== common/pq_consts.svh ====
`ifndef PQ_CONSTS_SVH
`define PQ_CONSTS_SVH

////////////////////////////////////////
// Queue geometry
////////////////////////////////////////

// Number of key slots in the store
`define PQ_DEPTH 16

// Key width in bits
`define PQ_DATA_W 16

// Occupancy counter covers 0 through PQ_DEPTH
`define PQ_CNT_W 5

// Slot address width
`define PQ_ADDR_W 4

`endif
